/* common/gtx_pkg.sv */
package gtx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane count
  ////////////////////////////////////////////////////////////////////////////

  // Transceiver lanes in the quad
  // The top level takes its own LANES parameter from this default
  localparam int unsigned LANES = 4;

  // One bit per lane
  // Carries the reset-done flags, ready levels, error strobes and force-error
  typedef logic [LANES-1:0] lane_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // PRBS pattern select
  ////////////////////////////////////////////////////////////////////////////

  // Pattern select field of the TX generator and RX checker
  typedef logic [2:0] prbs_mode_t;

  // Generator and checker disabled
  localparam prbs_mode_t PRBS_OFF = 3'b000;

  // PRBS-7 pattern on both sides of the link
  localparam prbs_mode_t PRBS_7 = 3'b001;

  ////////////////////////////////////////////////////////////////////////////
  // Error counting
  ////////////////////////////////////////////////////////////////////////////

  // Saturating PRBS error count of one lane
  typedef logic [7:0] err_count_t;

  // Count holds here instead of wrapping
  localparam err_count_t ERR_COUNT_MAX = 8'hFF;

endpackage

/* common/drp_pkg.sv */
package drp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // DRP port widths
  ////////////////////////////////////////////////////////////////////////////

  // Register address on the dynamic reconfiguration port
  typedef logic [7:0] drp_addr_t;

  // Read and write data word
  typedef logic [15:0] drp_data_t;

  // Transceiver status register polled while the link is up
  localparam drp_addr_t STATUS_ADDR = 8'h82;

  ////////////////////////////////////////////////////////////////////////////
  // Reader FSM
  ////////////////////////////////////////////////////////////////////////////

  // IDLE      wait for link up
  // ISSUE     single-cycle enable with the address on the port
  // WAIT_RDY  read outstanding, waiting for drdy
  // DONE      captured word presented with a valid pulse
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RDY,
    DONE
  } drp_state_t;

endpackage

/* hw/reset_request.sv */
`timescale 1ns/10ps

module reset_request #(
  parameter int unsigned RESET_HOLD = 8
) (
  input  logic gtx0_txusrclk2_i,
  input  logic gtx0_rxresetdone_i_r,
  input  logic tx_reset_btn_i,
  input  logic rx_reset_btn_i,
  output logic gtx_reset_o,
  output logic lane_clear_o
);

  // Hold counter wide enough for the full stretch
  localparam int unsigned HOLD_W = $clog2(RESET_HOLD + 1);

  logic              btn_r;
  logic [HOLD_W-1:0] hold_cnt;
  logic              hold_active;

  // Either button resets the whole quad, TX and RX together
  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      btn_r <= 1'b0;
    else
      btn_r <= tx_reset_btn_i | rx_reset_btn_i;
  end

  // Registered press covers the first cycle
  // Counter covers the remaining RESET_HOLD-1 cycles
  // A new press while counting restarts the stretch
  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      hold_cnt <= '0;
    else if (btn_r)
      hold_cnt <= HOLD_W'(RESET_HOLD - 1);
    else if (hold_cnt != '0)
      hold_cnt <= hold_cnt - 1'b1;
  end

  assign hold_active = btn_r | (hold_cnt != '0);

  // Same stretched pulse to the transceiver and to the lane synchronizers
  assign gtx_reset_o  = hold_active;
  assign lane_clear_o = hold_active;

  // Reset must be gone once the buttons have been quiet for the full hold
  a_reset_bounded : assert property (
    @(posedge gtx0_txusrclk2_i) disable iff (!gtx0_rxresetdone_i_r)
    (!btn_r)[*RESET_HOLD] |-> !gtx_reset_o
  );

endmodule

/* lane_sync/lane_sync.sv */
`timescale 1ns/10ps

module lane_sync
  import gtx_pkg::*;
(
  input  logic       gtx0_txusrclk2_i,
  input  logic       gtx0_rxresetdone_i_r,
  input  logic       tx_resetdone_i,
  input  logic       rx_resetdone_i,
  input  logic       rx_prbs_err_i,
  input  logic       force_err_i,
  input  logic       lane_clear_i,
  input  logic       prbs_cnt_reset_i,
  output logic       tx_ready_o,
  output logic       rx_ready_o,
  output logic       tx_force_err_o,
  output err_count_t err_count_o
);

  logic       tx_chain_rst_n;
  logic       tx_done_r;
  logic       tx_done_r2;
  logic       rx_done_s;
  logic       rx_chain_rst_n;
  logic       rx_done_r;
  logic       rx_done_r2;
  logic       rx_done_r3;
  logic       rx_check_reset;
  logic       cnt_en;
  err_count_t err_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Reset-done synchronizers
  ////////////////////////////////////////////////////////////////////////////

  // TX chain drops at once when the flag falls, rises after two edges
  assign tx_chain_rst_n = tx_resetdone_i & gtx0_rxresetdone_i_r;

  always_ff @(posedge gtx0_txusrclk2_i or negedge tx_chain_rst_n)
  begin
    if (!tx_chain_rst_n)
    begin
      tx_done_r  <= 1'b0;
      tx_done_r2 <= 1'b0;
    end
    else
    begin
      tx_done_r  <= 1'b1;
      tx_done_r2 <= tx_done_r;
    end
  end

  // RX flag sampled once first
  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      rx_done_s <= 1'b0;
    else
      rx_done_s <= rx_resetdone_i;
  end

  // Then a two-flop chain cleared by the low sampled flag
  assign rx_chain_rst_n = rx_done_s & gtx0_rxresetdone_i_r;

  always_ff @(posedge gtx0_txusrclk2_i or negedge rx_chain_rst_n)
  begin
    if (!rx_chain_rst_n)
    begin
      rx_done_r  <= 1'b0;
      rx_done_r2 <= 1'b0;
    end
    else
    begin
      rx_done_r  <= rx_done_s;
      rx_done_r2 <= rx_done_r;
    end
  end

  // Third stage releases the checker one cycle after rx_ready
  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      rx_done_r3 <= 1'b0;
    else
      rx_done_r3 <= rx_done_r2;
  end

  assign rx_check_reset = ~rx_done_r3;

  // Stretched reset request masks both ready levels
  assign tx_ready_o = tx_done_r2 & ~lane_clear_i;
  assign rx_ready_o = rx_done_r2 & ~lane_clear_i;

  ////////////////////////////////////////////////////////////////////////////
  // Force error and error counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      tx_force_err_o <= 1'b0;
    else
      tx_force_err_o <= force_err_i;
  end

  // Count only with the test running and the checker out of reset
  assign cnt_en = ~prbs_cnt_reset_i & ~rx_check_reset;

  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      err_cnt <= '0;
    else if (prbs_cnt_reset_i)
      err_cnt <= '0;
    else if (cnt_en && rx_prbs_err_i && (err_cnt != ERR_COUNT_MAX))
      err_cnt <= err_cnt + 1'b1;
  end

  assign err_count_o = err_cnt;

  // Full count stays full until the test controls clear it
  a_no_wrap : assert property (
    @(posedge gtx0_txusrclk2_i) disable iff (!gtx0_rxresetdone_i_r)
    (err_cnt == ERR_COUNT_MAX) && !prbs_cnt_reset_i |=> err_cnt == ERR_COUNT_MAX
  );

endmodule

/* hw/link_monitor.sv */
`timescale 1ns/10ps

module link_monitor
  import gtx_pkg::*;
#(
  parameter int unsigned LANES = 4
) (
  input  logic       gtx0_txusrclk2_i,
  input  logic       gtx0_rxresetdone_i_r,
  input  lane_vec_t  tx_ready_i,
  input  lane_vec_t  rx_ready_i,
  output prbs_mode_t tx_prbs_mode_o,
  output prbs_mode_t rx_prbs_mode_o,
  output logic       prbs_cnt_reset_o,
  output logic       link_up_o
);

  logic       all_done;
  prbs_mode_t tx_mode_q;
  prbs_mode_t rx_mode_q;
  logic       link_up_q;

  // Every lane ready in both directions
  assign all_done = (&tx_ready_i[LANES-1:0]) & (&rx_ready_i[LANES-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // PRBS test controls
  ////////////////////////////////////////////////////////////////////////////

  // Pattern on only once the whole quad is up
  // Any lane dropping turns the test off on the next edge
  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
    begin
      tx_mode_q <= PRBS_OFF;
      rx_mode_q <= PRBS_OFF;
      link_up_q <= 1'b0;
    end
    else if (all_done)
    begin
      tx_mode_q <= PRBS_7;
      rx_mode_q <= PRBS_7;
      link_up_q <= 1'b1;
    end
    else
    begin
      tx_mode_q <= PRBS_OFF;
      rx_mode_q <= PRBS_OFF;
      link_up_q <= 1'b0;
    end
  end

  assign tx_prbs_mode_o = tx_mode_q;
  assign rx_prbs_mode_o = rx_mode_q;

  // Counters held in reset whenever the link is down
  assign prbs_cnt_reset_o = ~link_up_q;
  assign link_up_o        = link_up_q;

endmodule

/* drp_reader/drp_reader.sv */
`timescale 1ns/10ps

module drp_reader
  import drp_pkg::*;
(
  input  logic      gtx0_txusrclk2_i,
  input  logic      gtx0_rxresetdone_i_r,
  input  logic      link_up_i,
  input  logic      drp_drdy_i,
  input  drp_data_t drp_do_i,
  output logic      drp_en_o,
  output logic      drp_we_o,
  output drp_addr_t drp_addr_o,
  output drp_data_t drp_di_o,
  output drp_data_t status_data_o,
  output logic      status_valid_o
);

  drp_state_t state_q;
  drp_state_t state_d;
  drp_data_t  rd_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    if (!gtx0_rxresetdone_i_r)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      // Start a read whenever the link is up
      IDLE:
      begin
        if (link_up_i)
          state_d = ISSUE;
      end
      // Enable lasts this one cycle only
      ISSUE:
        state_d = WAIT_RDY;
      // Latency is up to the port, drdy ends it
      // A read in flight is finished even if the link drops
      WAIT_RDY:
      begin
        if (drp_drdy_i)
          state_d = DONE;
      end
      DONE:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  // Capture the returned word on ready
  always_ff @(posedge gtx0_txusrclk2_i)
  begin
    if ((state_q == WAIT_RDY) && drp_drdy_i)
      rd_data_q <= drp_do_i;
  end

  // Read only, fixed status address
  assign drp_en_o   = (state_q == ISSUE);
  assign drp_we_o   = 1'b0;
  assign drp_addr_o = STATUS_ADDR;
  assign drp_di_o   = '0;

  // Word valid for one cycle, overwritten by the next read
  assign status_data_o  = rd_data_q;
  assign status_valid_o = (state_q == DONE);

  // Each enable is a read of the status register
  // No second enable goes out before the first one is answered
  a_single_read : assert property (
    @(posedge gtx0_txusrclk2_i) disable iff (!gtx0_rxresetdone_i_r)
    drp_en_o |-> (!drp_we_o && (drp_addr_o == STATUS_ADDR))
      ##1 (!drp_en_o throughout drp_drdy_i[->1])
  );

endmodule

/* hw/prbs_link_top.sv */
`timescale 1ns/10ps

module prbs_link_top
  import gtx_pkg::*;
  import drp_pkg::*;
#(
  parameter int unsigned LANES      = gtx_pkg::LANES,
  parameter int unsigned RESET_HOLD = 8
) (
  input  logic       gtx0_txusrclk2_i,
  input  logic       gtx0_rxresetdone_i_r,
  input  logic       tx_reset_btn_i,
  input  logic       rx_reset_btn_i,
  input  lane_vec_t  force_err_btn_i,
  input  lane_vec_t  tx_resetdone_i,
  input  lane_vec_t  rx_resetdone_i,
  input  lane_vec_t  rx_prbs_err_i,
  input  logic       drp_drdy_i,
  input  drp_data_t  drp_do_i,
  output logic       gtx_reset_o,
  output lane_vec_t  tx_force_err_o,
  output prbs_mode_t tx_prbs_mode_o,
  output prbs_mode_t rx_prbs_mode_o,
  output logic       prbs_cnt_reset_o,
  output err_count_t err_count_o [LANES],
  output logic       drp_en_o,
  output logic       drp_we_o,
  output drp_addr_t  drp_addr_o,
  output drp_data_t  drp_di_o,
  output drp_data_t  status_data_o,
  output logic       status_valid_o
);

  logic      lane_clear;
  lane_vec_t tx_ready;
  lane_vec_t rx_ready;
  logic      link_up;

  // Lane vectors come from the package, the count must agree
  if ($bits(lane_vec_t) != LANES)
  begin : g_lane_check
    $error("LANES does not match the lane vector width");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset request and per-lane synchronizers
  ////////////////////////////////////////////////////////////////////////////

  reset_request #(
    .RESET_HOLD (RESET_HOLD)
  ) u_reset_request (
    .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
    .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
    .tx_reset_btn_i       (tx_reset_btn_i),
    .rx_reset_btn_i       (rx_reset_btn_i),
    .gtx_reset_o          (gtx_reset_o),
    .lane_clear_o         (lane_clear)
  );

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    lane_sync u_lane_sync (
      .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
      .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
      .tx_resetdone_i       (tx_resetdone_i[g]),
      .rx_resetdone_i       (rx_resetdone_i[g]),
      .rx_prbs_err_i        (rx_prbs_err_i[g]),
      .force_err_i          (force_err_btn_i[g]),
      .lane_clear_i         (lane_clear),
      .prbs_cnt_reset_i     (prbs_cnt_reset_o),
      .tx_ready_o           (tx_ready[g]),
      .rx_ready_o           (rx_ready[g]),
      .tx_force_err_o       (tx_force_err_o[g]),
      .err_count_o          (err_count_o[g])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link controls and status polling
  ////////////////////////////////////////////////////////////////////////////

  link_monitor #(
    .LANES (LANES)
  ) u_link_monitor (
    .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
    .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
    .tx_ready_i           (tx_ready),
    .rx_ready_i           (rx_ready),
    .tx_prbs_mode_o       (tx_prbs_mode_o),
    .rx_prbs_mode_o       (rx_prbs_mode_o),
    .prbs_cnt_reset_o     (prbs_cnt_reset_o),
    .link_up_o            (link_up)
  );

  // Status register of lane 0 only
  drp_reader u_drp_reader (
    .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
    .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
    .link_up_i            (link_up),
    .drp_drdy_i           (drp_drdy_i),
    .drp_do_i             (drp_do_i),
    .drp_en_o             (drp_en_o),
    .drp_we_o             (drp_we_o),
    .drp_addr_o           (drp_addr_o),
    .drp_di_o             (drp_di_o),
    .status_data_o        (status_data_o),
    .status_valid_o       (status_valid_o)
  );

endmodule

/* tests/prbs_checker.sv */
`timescale 1ns/10ps

module prbs_checker
  import gtx_pkg::*;
  import drp_pkg::*;
#(
  parameter int unsigned LANES      = 4,
  parameter int unsigned RESET_HOLD = 8
) (
  input  logic       gtx0_txusrclk2_i,
  input  logic       gtx0_rxresetdone_i_r,
  input  logic       tx_reset_btn_i,
  input  logic       rx_reset_btn_i,
  input  lane_vec_t  force_err_btn_i,
  input  lane_vec_t  tx_resetdone_i,
  input  lane_vec_t  rx_resetdone_i,
  input  lane_vec_t  rx_prbs_err_i,
  input  logic       drp_drdy_i,
  input  drp_data_t  drp_do_i,
  input  logic       gtx_reset_i,
  input  lane_vec_t  tx_force_err_i,
  input  prbs_mode_t tx_prbs_mode_i,
  input  prbs_mode_t rx_prbs_mode_i,
  input  logic       prbs_cnt_reset_i,
  input  err_count_t err_count_i [LANES],
  input  logic       drp_en_i,
  input  logic       drp_we_i,
  input  drp_addr_t  drp_addr_i,
  input  drp_data_t  drp_di_i,
  input  logic       status_valid_i,
  input  drp_data_t  status_data_i,
  output int         errors_o,
  output int         checks_o,
  output int         reads_o
);

  // Cycles since a button was last sampled high
  int unsigned since_btn;
  // Consecutive edges with the reset-done flag seen high
  int unsigned tx_cnt [LANES];
  int unsigned rx_cnt [LANES];
  // Third rx stage, checker out of reset
  logic        check_en [LANES];
  err_count_t  cnt_exp [LANES];
  lane_vec_t   force_exp;
  logic        link_up;
  logic        link_prev;
  // Words returned by the DRP model, oldest first
  drp_data_t   rd_q [$];
  int          errors = 0;
  int          checks = 0;
  int          reads = 0;

  assign errors_o = errors;
  assign checks_o = checks;
  assign reads_o  = reads;

  // Stretched reset is high for RESET_HOLD cycles from the sampled press
  function automatic logic reset_exp();
    return since_btn < RESET_HOLD;
  endfunction

  // TX ready after 2 edges, RX ready after 3, both masked by the stretch
  function automatic logic all_ready();
    logic r;
    int   i;
    r = 1'b1;
    for (i = 0; i < LANES; i++)
      r = r & tx_resetdone_i[i] & (tx_cnt[i] >= 2) & (rx_cnt[i] >= 3);
    return r & ~reset_exp();
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, advanced on every rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge gtx0_txusrclk2_i or negedge gtx0_rxresetdone_i_r)
  begin
    int i;
    if (!gtx0_rxresetdone_i_r)
    begin
      since_btn <= RESET_HOLD;
      link_up   <= 1'b0;
      link_prev <= 1'b0;
      force_exp <= '0;
      for (i = 0; i < LANES; i++)
      begin
        tx_cnt[i]   <= 0;
        rx_cnt[i]   <= 0;
        check_en[i] <= 1'b0;
        cnt_exp[i]  <= '0;
      end
      rd_q.delete();
    end
    else
    begin
      // A press restarts the stretch
      if (tx_reset_btn_i || rx_reset_btn_i)
        since_btn <= 0;
      else if (since_btn < RESET_HOLD)
        since_btn <= since_btn + 1;
      link_up   <= all_ready();
      link_prev <= link_up;
      force_exp <= force_err_btn_i;
      for (i = 0; i < LANES; i++)
      begin
        tx_cnt[i]   <= !tx_resetdone_i[i] ? 0 : (tx_cnt[i] < 2 ? tx_cnt[i] + 1 : 2);
        rx_cnt[i]   <= !rx_resetdone_i[i] ? 0 : (rx_cnt[i] < 3 ? rx_cnt[i] + 1 : 3);
        check_en[i] <= (rx_cnt[i] >= 3);
        // Counts cleared with the link down, saturate at the top
        if (!link_up)
          cnt_exp[i] <= '0;
        else if (check_en[i] && rx_prbs_err_i[i] && (cnt_exp[i] != 8'hFF))
          cnt_exp[i] <= cnt_exp[i] + 1'b1;
      end
      if (drp_drdy_i)
        rd_q.push_back(drp_do_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare on the falling edge, all outputs settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge gtx0_txusrclk2_i)
  begin
    int        i;
    drp_data_t want;
    check_value("gtx_reset_o", gtx_reset_i, reset_exp());
    check_value("tx_prbs_mode_o", tx_prbs_mode_i, link_up ? PRBS_7 : PRBS_OFF);
    check_value("rx_prbs_mode_o", rx_prbs_mode_i, link_up ? PRBS_7 : PRBS_OFF);
    check_value("prbs_cnt_reset_o", prbs_cnt_reset_i, !link_up);
    check_value("tx_force_err_o", tx_force_err_i, force_exp);
    for (i = 0; i < LANES; i++)
      check_value($sformatf("err_count_o[%0d]", i), err_count_i[i], cnt_exp[i]);
    check_value("drp_we_o", drp_we_i, 1'b0);
    // Reads only of the status register, only with the link up
    // A read carries no write data
    if (drp_en_i)
    begin
      check_value("drp_addr_o", drp_addr_i, STATUS_ADDR);
      check_value("drp_di_o", drp_di_i, 16'h0000);
      if (!link_prev)
      begin
        errors++;
        $display("DRP read started while the link was down, at %0t", $time);
      end
    end
    // Each valid pulse shows the next returned word in order
    if (status_valid_i)
    begin
      if (rd_q.size() == 0)
      begin
        errors++;
        $display("status_valid_o pulsed with no DRP answer pending, at %0t", $time);
      end
      else
      begin
        want = rd_q.pop_front();
        check_value("status_data_o", status_data_i, want);
        reads++;
      end
    end
  end

endmodule

/* tests/tb_prbs_link.sv */
`timescale 1ns/10ps

module tb_prbs_link
  import gtx_pkg::*;
  import drp_pkg::*;
();

  localparam int unsigned RESET_HOLD   = 8;
  localparam int unsigned NUM_STEPS    = 19;
  localparam int unsigned READ_TIMEOUT = 200;

  // One row of the stimulus table
  typedef struct packed {
    logic [3:0]  test;
    lane_vec_t   tx_done;
    lane_vec_t   rx_done;
    lane_vec_t   prbs_err;
    lane_vec_t   force_err;
    logic        tx_btn;
    logic        rx_btn;
    logic [15:0] cycles;
    logic [3:0]  reads;
  } step_t;

  logic       gtx0_txusrclk2_i;
  logic       gtx0_rxresetdone_i_r;
  logic       tx_reset_btn;
  logic       rx_reset_btn;
  lane_vec_t  force_err_btn;
  lane_vec_t  tx_resetdone;
  lane_vec_t  rx_resetdone;
  lane_vec_t  rx_prbs_err;
  logic       drp_drdy = 1'b0;
  drp_data_t  drp_do = '0;
  logic       gtx_reset;
  lane_vec_t  tx_force_err;
  prbs_mode_t tx_prbs_mode;
  prbs_mode_t rx_prbs_mode;
  logic       prbs_cnt_reset;
  err_count_t err_count [LANES];
  logic       drp_en;
  logic       drp_we;
  drp_addr_t  drp_addr;
  drp_data_t  drp_di;
  drp_data_t  status_data;
  logic       status_valid;
  int         chk_errors;
  int         chk_checks;
  int         chk_reads;

  step_t      steps [NUM_STEPS];
  string      test_name [1:6];
  int         tb_fails = 0;
  int         err_base = 0;
  int         tests_run = 0;
  int         failed_tests = 0;

  prbs_link_top #(
    .LANES      (LANES),
    .RESET_HOLD (RESET_HOLD)
  ) UUT (
    .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
    .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
    .tx_reset_btn_i       (tx_reset_btn),
    .rx_reset_btn_i       (rx_reset_btn),
    .force_err_btn_i      (force_err_btn),
    .tx_resetdone_i       (tx_resetdone),
    .rx_resetdone_i       (rx_resetdone),
    .rx_prbs_err_i        (rx_prbs_err),
    .drp_drdy_i           (drp_drdy),
    .drp_do_i             (drp_do),
    .gtx_reset_o          (gtx_reset),
    .tx_force_err_o       (tx_force_err),
    .tx_prbs_mode_o       (tx_prbs_mode),
    .rx_prbs_mode_o       (rx_prbs_mode),
    .prbs_cnt_reset_o     (prbs_cnt_reset),
    .err_count_o          (err_count),
    .drp_en_o             (drp_en),
    .drp_we_o             (drp_we),
    .drp_addr_o           (drp_addr),
    .drp_di_o             (drp_di),
    .status_data_o        (status_data),
    .status_valid_o       (status_valid)
  );

  prbs_checker #(
    .LANES      (LANES),
    .RESET_HOLD (RESET_HOLD)
  ) u_checker (
    .gtx0_txusrclk2_i     (gtx0_txusrclk2_i),
    .gtx0_rxresetdone_i_r (gtx0_rxresetdone_i_r),
    .tx_reset_btn_i       (tx_reset_btn),
    .rx_reset_btn_i       (rx_reset_btn),
    .force_err_btn_i      (force_err_btn),
    .tx_resetdone_i       (tx_resetdone),
    .rx_resetdone_i       (rx_resetdone),
    .rx_prbs_err_i        (rx_prbs_err),
    .drp_drdy_i           (drp_drdy),
    .drp_do_i             (drp_do),
    .gtx_reset_i          (gtx_reset),
    .tx_force_err_i       (tx_force_err),
    .tx_prbs_mode_i       (tx_prbs_mode),
    .rx_prbs_mode_i       (rx_prbs_mode),
    .prbs_cnt_reset_i     (prbs_cnt_reset),
    .err_count_i          (err_count),
    .drp_en_i             (drp_en),
    .drp_we_i             (drp_we),
    .drp_addr_i           (drp_addr),
    .drp_di_i             (drp_di),
    .status_valid_i       (status_valid),
    .status_data_i        (status_data),
    .errors_o             (chk_errors),
    .checks_o             (chk_checks),
    .reads_o              (chk_reads)
  );

  // 20 ns user clock
  initial
    gtx0_txusrclk2_i = 1'b0;
  always #10 gtx0_txusrclk2_i = ~gtx0_txusrclk2_i;

  ////////////////////////////////////////////////////////////////////////////
  // DRP port stand-in, answers each enable after 1 to 6 cycles
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned delay;
    void'($urandom(35180));
    delay = 0;
    forever
    begin
      @(posedge gtx0_txusrclk2_i);
      drp_drdy <= 1'b0;
      if (drp_en)
        delay = $urandom_range(6, 1);
      else if (delay != 0)
      begin
        delay = delay - 1;
        // Random status word with its ready strobe
        if (delay == 0)
        begin
          drp_drdy <= 1'b1;
          drp_do   <= drp_data_t'($urandom);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  // test, tx done, rx done, prbs err, force err, tx btn, rx btn, cycles, reads
  task automatic fill_steps();
    test_name[1] = "reset values";
    test_name[2] = "ready sync and PRBS on";
    test_name[3] = "error counting";
    test_name[4] = "DRP status reads";
    test_name[5] = "reset buttons";
    test_name[6] = "lane drop and force error";
    steps[0]  = '{4'd1, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, 16'd12, 4'd0};
    steps[1]  = '{4'd2, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd8, 4'd0};
    // Lane 2 RX held low, modes must stay off
    steps[2]  = '{4'd2, 4'hF, 4'hB, 4'h0, 4'h0, 1'b0, 1'b0, 16'd8, 4'd0};
    steps[3]  = '{4'd2, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd10, 4'd0};
    steps[4]  = '{4'd3, 4'hF, 4'hF, 4'h5, 4'h0, 1'b0, 1'b0, 16'd5, 4'd0};
    steps[5]  = '{4'd3, 4'hF, 4'hF, 4'h2, 4'h0, 1'b0, 1'b0, 16'd3, 4'd0};
    steps[6]  = '{4'd3, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd2, 4'd0};
    // Lane 3 runs past the top of its counter
    steps[7]  = '{4'd3, 4'hF, 4'hF, 4'h8, 4'h0, 1'b0, 1'b0, 16'd300, 4'd0};
    steps[8]  = '{4'd3, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd4, 4'd0};
    steps[9]  = '{4'd4, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd2, 4'd5};
    steps[10] = '{4'd5, 4'hF, 4'hF, 4'h0, 4'h0, 1'b1, 1'b0, 16'd1, 4'd0};
    steps[11] = '{4'd5, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd14, 4'd0};
    steps[12] = '{4'd5, 4'hF, 4'hF, 4'h3, 4'h0, 1'b0, 1'b0, 16'd4, 4'd0};
    steps[13] = '{4'd5, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b1, 16'd1, 4'd0};
    steps[14] = '{4'd5, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd14, 4'd2};
    // Lane 0 TX drops with errors arriving
    steps[15] = '{4'd6, 4'hE, 4'hF, 4'hF, 4'h5, 1'b0, 1'b0, 16'd6, 4'd0};
    steps[16] = '{4'd6, 4'hF, 4'hF, 4'h0, 4'hA, 1'b0, 1'b0, 16'd8, 4'd0};
    steps[17] = '{4'd6, 4'hF, 4'hF, 4'hF, 4'hF, 1'b0, 1'b0, 16'd3, 4'd0};
    steps[18] = '{4'd6, 4'hF, 4'hF, 4'h0, 4'h0, 1'b0, 1'b0, 16'd4, 4'd1};
  endtask

  // Wait for n more status words, bounded
  task automatic wait_reads(input int unsigned n);
    int          target;
    int unsigned t;
    target = chk_reads + n;
    t = 0;
    while ((chk_reads < target) && (t < READ_TIMEOUT))
    begin
      @(posedge gtx0_txusrclk2_i);
      t++;
    end
    if (chk_reads < target)
    begin
      tb_fails++;
      $display("Timeout waiting for %0d status reads within %0d cycles", n, READ_TIMEOUT);
    end
  endtask

  task automatic apply_step(input step_t s);
    tx_resetdone  <= s.tx_done;
    rx_resetdone  <= s.rx_done;
    rx_prbs_err   <= s.prbs_err;
    force_err_btn <= s.force_err;
    tx_reset_btn  <= s.tx_btn;
    rx_reset_btn  <= s.rx_btn;
    repeat (s.cycles) @(posedge gtx0_txusrclk2_i);
    if (s.reads != 0)
      wait_reads(s.reads);
  endtask

  task automatic report_test(input int unsigned id);
    int total;
    int delta;
    total = chk_errors + tb_fails;
    delta = total - err_base;
    err_base = total;
    tests_run++;
    if (delta == 0)
      $display("test %0d %s: ok", id, test_name[id]);
    else
    begin
      failed_tests++;
      $display("test %0d %s: %0d errors", id, test_name[id], delta);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned idx;
    logic [3:0]  cur_test;
    fill_steps();
    gtx0_rxresetdone_i_r = 1'b0;
    tx_reset_btn         = 1'b0;
    rx_reset_btn         = 1'b0;
    force_err_btn        = '0;
    tx_resetdone         = '0;
    rx_resetdone         = '0;
    rx_prbs_err          = '0;
    repeat (4) @(posedge gtx0_txusrclk2_i);
    gtx0_rxresetdone_i_r <= 1'b1;
    cur_test = steps[0].test;
    for (idx = 0; idx < NUM_STEPS; idx++)
    begin
      if (steps[idx].test != cur_test)
      begin
        report_test(cur_test);
        cur_test = steps[idx].test;
      end
      apply_step(steps[idx]);
    end
    report_test(cur_test);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, failed_tests, chk_checks, chk_errors + tb_fails);
    if ((failed_tests == 0) && (chk_errors + tb_fails == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* project.f */
common/gtx_pkg.sv
common/drp_pkg.sv
hw/reset_request.sv
lane_sync/lane_sync.sv
hw/link_monitor.sv
drp_reader/drp_reader.sv
hw/prbs_link_top.sv
tests/prbs_checker.sv
tests/tb_prbs_link.sv

/* Bender.yml */
package:
  name: prbs_link

sources:
  - files:
      - common/gtx_pkg.sv
      - common/drp_pkg.sv
      - hw/reset_request.sv
      - lane_sync/lane_sync.sv
      - hw/link_monitor.sv
      - drp_reader/drp_reader.sv
      - hw/prbs_link_top.sv
  - target: test
    files:
      - tests/prbs_checker.sv
      - tests/tb_prbs_link.sv
